// ==== src/dbg_biu_defines.svh ====
/*
  Debug bus interface unit build constants
  Bus widths, synchronizer depth and the AXI OKAY code
*/
`ifndef DBG_BIU_DEFINES_SVH
`define DBG_BIU_DEFINES_SVH

// AXI address width, full 32-bit debug address
`define DBG_ADDR_W 32

// Data bus is fixed at 64 bits
`define DBG_DATA_W 64

// One strobe bit per byte lane
`define DBG_STRB_W 8

// Flops in each toggle synchronizer, edge flop not counted
`define DBG_SYNC_STAGES 2

// AXI OKAY response code
`define DBG_RESP_OKAY 2'b00

`endif

// ==== src/axi_pkg.sv ====
/*
  AXI side types for the debug bus interface unit
  Response code, transfer size code and completion record
*/
`include "dbg_biu_defines.svh"

package axi_pkg;

  ////////////////////////////////////////
  // Response and size codes
  ////////////////////////////////////////

  // Raw BRESP / RRESP field
  typedef logic [1:0] axi_resp_t;

  // AxSIZE is log2 of the bytes per beat
  typedef enum logic [2:0]
  {
    AXI_SIZE_1B = 3'd0,
    AXI_SIZE_2B = 3'd1,
    AXI_SIZE_4B = 3'd2,
    AXI_SIZE_8B = 3'd3
  } axi_size_t;

  ////////////////////////////////////////
  // Completion of one access
  ////////////////////////////////////////

  // Read data still on its bus lanes
  // Zero for a write completion
  typedef struct packed
  {
    logic [`DBG_DATA_W-1:0] rdata;
    axi_resp_t              resp;
  } axi_cpl_t;

endpackage

// ==== src/dbg_pkg.sv ====
/*
  Debug side types for the debug bus interface unit
  Word size code and the captured request
*/
`include "dbg_biu_defines.svh"

package dbg_pkg;

  // Request carries an AXI size code
  import axi_pkg::*;

  // Word size as shifted in by the debug module
  // Unlisted codes are treated as 8 bytes
  typedef enum logic [3:0]
  {
    DBG_WSIZE_1 = 4'h1,
    DBG_WSIZE_2 = 4'h2,
    DBG_WSIZE_4 = 4'h4,
    DBG_WSIZE_8 = 4'h8
  } dbg_wsize_t;

  // Request held in TCK domain, read in AXI domain
  // Write data already sits on its byte lanes
  typedef struct packed
  {
    logic [`DBG_ADDR_W-1:0] addr;
    logic [`DBG_DATA_W-1:0] wdata;
    logic [`DBG_STRB_W-1:0] strb;
    axi_size_t              size;
    logic                   write;
  } dbg_req_t;

endpackage

// ==== src/dbg_req_capture.sv ====
/*
  Debug request capture, TCK domain
  Decodes byte lanes, places write data and hands the request over
*/
`timescale 1ns/100ps
`include "dbg_biu_defines.svh"

module dbg_req_capture
  import dbg_pkg::*;
  import axi_pkg::*;
(
  input  logic                   tck_i,
  input  logic                   trstn_i,
  input  logic                   strobe_i,
  input  logic                   rd_wrn_i,
  input  logic [`DBG_ADDR_W-1:0] addr_i,
  input  logic [`DBG_DATA_W-1:0] data_i,
  input  dbg_wsize_t             word_size_i,
  input  logic                   done_tgl_i,
  output logic                   rdy_o,
  output dbg_req_t               req_o,
  output logic                   start_tgl_o
);

  logic                         accept;
  logic [2:0]                   lo_lane;
  logic [`DBG_STRB_W-1:0]       lane_mask;
  logic [`DBG_STRB_W-1:0]       be_dec;
  axi_size_t                    size_dec;
  logic [`DBG_DATA_W-1:0]       rjust;
  logic [`DBG_DATA_W-1:0]       wdata_dec;
  logic [`DBG_SYNC_STAGES-1:0]  done_sync_q;
  logic                         done_edge_q;
  logic                         done_seen;

  // Strobe only counts while idle
  assign accept = strobe_i & rdy_o;

  ////////////////////////////////////////
  // Lane decode and write data placement
  ////////////////////////////////////////

  // Short words arrive in the top bytes of data_i (LSB-first shift)
  // Right-justify them, then move up to the lowest enabled lane
  always_comb
  begin
    case (word_size_i)
      DBG_WSIZE_1:
      begin
        lo_lane   = addr_i[2:0];
        lane_mask = 8'h01;
        size_dec  = AXI_SIZE_1B;
        rjust     = data_i >> (`DBG_DATA_W - 8);
      end
      DBG_WSIZE_2:
      begin
        lo_lane   = {addr_i[2:1], 1'b0};
        lane_mask = 8'h03;
        size_dec  = AXI_SIZE_2B;
        rjust     = data_i >> (`DBG_DATA_W - 16);
      end
      DBG_WSIZE_4:
      begin
        lo_lane   = {addr_i[2], 2'b00};
        lane_mask = 8'h0f;
        size_dec  = AXI_SIZE_4B;
        rjust     = data_i >> (`DBG_DATA_W - 32);
      end
      // 8 bytes and any unknown code
      default:
      begin
        lo_lane   = 3'd0;
        lane_mask = 8'hff;
        size_dec  = AXI_SIZE_8B;
        rjust     = data_i;
      end
    endcase
    be_dec    = lane_mask << lo_lane;
    wdata_dec = rjust << {lo_lane, 3'b000};
  end

  // Request register, stable until the next acceptance
  always_ff @(posedge tck_i)
  begin
    if (accept)
    begin
      req_o.addr  <= addr_i;
      req_o.wdata <= wdata_dec;
      req_o.strb  <= be_dec;
      req_o.size  <= size_dec;
      req_o.write <= ~rd_wrn_i;
    end
  end

  ////////////////////////////////////////
  // Handshake with the AXI domain
  ////////////////////////////////////////

  // Done toggle into TCK, last flop used for edge detect
  always_ff @(posedge tck_i or negedge trstn_i)
  begin
    if (!trstn_i)
    begin
      done_sync_q <= '0;
      done_edge_q <= 1'b0;
    end
    else
    begin
      done_sync_q <= {done_sync_q[`DBG_SYNC_STAGES-2:0], done_tgl_i};
      done_edge_q <= done_sync_q[`DBG_SYNC_STAGES-1];
    end
  end

  assign done_seen = done_sync_q[`DBG_SYNC_STAGES-1] ^ done_edge_q;

  // Ready drops on acceptance, returns on completion
  always_ff @(posedge tck_i or negedge trstn_i)
  begin
    if (!trstn_i)
    begin
      rdy_o       <= 1'b1;
      start_tgl_o <= 1'b0;
    end
    else if (accept)
    begin
      rdy_o       <= 1'b0;
      start_tgl_o <= ~start_tgl_o;
    end
    else if (done_seen)
    begin
      rdy_o <= 1'b1;
    end
  end

  // Busy for at least one TCK cycle after each accepted strobe
  a_busy_after_accept : assert property (
    @(posedge tck_i) disable iff (!trstn_i)
    accept |=> !rdy_o
  );

endmodule

// ==== src/axi_single_access.sv ====
/*
  Single-beat AXI4 master, axi_aclk domain
  Picks up the start toggle and runs one address, data and response sequence
*/
`timescale 1ns/100ps
`include "dbg_biu_defines.svh"

module axi_single_access
  import dbg_pkg::*;
  import axi_pkg::*;
(
  input  logic                   axi_aclk,
  input  logic                   axi_aresetn,
  input  dbg_req_t               req_i,
  input  logic                   start_tgl_i,
  output logic                   cpl_valid_o,
  output axi_cpl_t               cpl_o,
  // Write address channel
  output logic                   aw_valid_o,
  output logic [`DBG_ADDR_W-1:0] aw_addr_o,
  output axi_size_t              aw_size_o,
  input  logic                   aw_ready_i,
  // Read address channel
  output logic                   ar_valid_o,
  output logic [`DBG_ADDR_W-1:0] ar_addr_o,
  output axi_size_t              ar_size_o,
  input  logic                   ar_ready_i,
  // Write data channel
  output logic                   w_valid_o,
  output logic [`DBG_DATA_W-1:0] w_data_o,
  output logic [`DBG_STRB_W-1:0] w_strb_o,
  output logic                   w_last_o,
  input  logic                   w_ready_i,
  // Write response channel
  input  logic                   b_valid_i,
  input  axi_resp_t              b_resp_i,
  output logic                   b_ready_o,
  // Read data channel
  input  logic                   r_valid_i,
  input  logic [`DBG_DATA_W-1:0] r_data_i,
  input  axi_resp_t              r_resp_i,
  output logic                   r_ready_o
);

  typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_DATA, ST_RESP} state_t;

  state_t                      state_q;
  logic [`DBG_SYNC_STAGES-1:0] start_sync_q;
  logic                        start_edge_q;
  logic                        start_seen;

  // Start toggle from TCK, request is already stable by now
  always_ff @(posedge axi_aclk or negedge axi_aresetn)
  begin
    if (!axi_aresetn)
    begin
      start_sync_q <= '0;
      start_edge_q <= 1'b0;
    end
    else
    begin
      start_sync_q <= {start_sync_q[`DBG_SYNC_STAGES-2:0], start_tgl_i};
      start_edge_q <= start_sync_q[`DBG_SYNC_STAGES-1];
    end
  end

  assign start_seen = start_sync_q[`DBG_SYNC_STAGES-1] ^ start_edge_q;

  ////////////////////////////////////////
  // Access FSM
  ////////////////////////////////////////

  // One state per handshake, any ready or valid stretches it
  always_ff @(posedge axi_aclk or negedge axi_aresetn)
  begin
    if (!axi_aresetn)
      state_q <= ST_IDLE;
    else
    begin
      case (state_q)
        ST_IDLE:
          if (start_seen)
            state_q <= ST_ADDR;
        ST_ADDR:
          if (req_i.write && aw_ready_i)
            state_q <= ST_DATA;
          else if (!req_i.write && ar_ready_i)
            state_q <= ST_RESP;
        ST_DATA:
          if (w_ready_i)
            state_q <= ST_RESP;
        default:
          if (cpl_valid_o)
            state_q <= ST_IDLE;
      endcase
    end
  end

  // Channel controls decoded from state and direction
  assign aw_valid_o = (state_q == ST_ADDR) &  req_i.write;
  assign ar_valid_o = (state_q == ST_ADDR) & ~req_i.write;
  assign w_valid_o  = (state_q == ST_DATA);
  assign w_last_o   = (state_q == ST_DATA);
  assign b_ready_o  = (state_q == ST_RESP) &  req_i.write;
  assign r_ready_o  = (state_q == ST_RESP) & ~req_i.write;

  // Payload straight from the held request
  assign aw_addr_o = req_i.addr;
  assign ar_addr_o = req_i.addr;
  assign aw_size_o = req_i.size;
  assign ar_size_o = req_i.size;
  assign w_data_o  = req_i.wdata;
  assign w_strb_o  = req_i.strb;

  // Completion pulses on the response handshake
  assign cpl_valid_o = (b_ready_o & b_valid_i) | (r_ready_o & r_valid_i);
  assign cpl_o.rdata = req_i.write ? '0 : r_data_i;
  assign cpl_o.resp  = req_i.write ? b_resp_i : r_resp_i;

  // AW must not be withdrawn before the slave takes it
  a_aw_hold : assert property (
    @(posedge axi_aclk) disable iff (!axi_aresetn)
    aw_valid_o && !aw_ready_i |=> aw_valid_o
  );

  // Never two address requests at once
  a_addr_onehot : assert property (
    @(posedge axi_aclk) disable iff (!axi_aresetn)
    !(aw_valid_o && ar_valid_o)
  );

endmodule

// ==== src/dbg_resp_align.sv ====
/*
  Response capture, axi_aclk domain
  Right-justifies read data, keeps the error flag and toggles done to TCK
*/
`timescale 1ns/100ps
`include "dbg_biu_defines.svh"

module dbg_resp_align
  import axi_pkg::*;
(
  input  logic                   axi_aclk,
  input  logic                   axi_aresetn,
  input  logic                   cpl_valid_i,
  input  axi_cpl_t               cpl_i,
  input  logic [`DBG_STRB_W-1:0] strb_i,
  output logic [`DBG_DATA_W-1:0] data_o,
  output logic                   err_o,
  output logic                   done_tgl_o
);

  logic [2:0]             lo_lane;
  logic [`DBG_DATA_W-1:0] rdata_shift;

  // Lowest enabled lane, scanned top down so the lowest one wins
  always_comb
  begin
    lo_lane = 3'd0;
    for (int i = `DBG_STRB_W - 1; i >= 0; i--)
    begin
      if (strb_i[i])
        lo_lane = 3'(i);
    end
  end

  // Zeros fill from the top
  assign rdata_shift = cpl_i.rdata >> {lo_lane, 3'b000};

  ////////////////////////////////////////
  // Result registers and done toggle
  ////////////////////////////////////////

  // Held for TCK until the next completion
  always_ff @(posedge axi_aclk or negedge axi_aresetn)
  begin
    if (!axi_aresetn)
    begin
      data_o     <= '0;
      err_o      <= 1'b0;
      done_tgl_o <= 1'b0;
    end
    else if (cpl_valid_i)
    begin
      data_o     <= rdata_shift;
      err_o      <= (cpl_i.resp != `DBG_RESP_OKAY);
      done_tgl_o <= ~done_tgl_o;
    end
  end

endmodule

// ==== src/dbg_axi_biu.sv ====
/*
  Debug to AXI4 bus interface unit
  TCK request capture, single-beat AXI master and response return
*/
`timescale 1ns/100ps
`include "dbg_biu_defines.svh"

module dbg_axi_biu
  import dbg_pkg::*;
  import axi_pkg::*;
(
  // Debug port, TCK domain
  input  logic                   tck_i,
  input  logic                   trstn_i,
  input  logic                   strobe_i,
  input  logic                   rd_wrn_i,
  input  logic [`DBG_ADDR_W-1:0] addr_i,
  input  logic [`DBG_DATA_W-1:0] data_i,
  input  dbg_wsize_t             word_size_i,
  output logic [`DBG_DATA_W-1:0] data_o,
  output logic                   rdy_o,
  output logic                   err_o,
  // AXI4 master
  input  logic                   axi_aclk,
  input  logic                   axi_aresetn,
  output logic                   m_axi_aw_valid_o,
  output logic [`DBG_ADDR_W-1:0] m_axi_aw_addr_o,
  output axi_size_t              m_axi_aw_size_o,
  input  logic                   m_axi_aw_ready_i,
  output logic                   m_axi_ar_valid_o,
  output logic [`DBG_ADDR_W-1:0] m_axi_ar_addr_o,
  output axi_size_t              m_axi_ar_size_o,
  input  logic                   m_axi_ar_ready_i,
  output logic                   m_axi_w_valid_o,
  output logic [`DBG_DATA_W-1:0] m_axi_w_data_o,
  output logic [`DBG_STRB_W-1:0] m_axi_w_strb_o,
  output logic                   m_axi_w_last_o,
  input  logic                   m_axi_w_ready_i,
  input  logic                   m_axi_b_valid_i,
  input  axi_resp_t              m_axi_b_resp_i,
  output logic                   m_axi_b_ready_o,
  input  logic                   m_axi_r_valid_i,
  input  logic [`DBG_DATA_W-1:0] m_axi_r_data_i,
  input  axi_resp_t              m_axi_r_resp_i,
  output logic                   m_axi_r_ready_o
);

  // Request crosses on its own, only the toggles are synchronized
  dbg_req_t req;
  logic     start_tgl;
  logic     done_tgl;
  logic     cpl_valid;
  axi_cpl_t cpl;

  dbg_req_capture i_req_capture (
    .tck_i       (tck_i),
    .trstn_i     (trstn_i),
    .strobe_i    (strobe_i),
    .rd_wrn_i    (rd_wrn_i),
    .addr_i      (addr_i),
    .data_i      (data_i),
    .word_size_i (word_size_i),
    .done_tgl_i  (done_tgl),
    .rdy_o       (rdy_o),
    .req_o       (req),
    .start_tgl_o (start_tgl)
  );

  axi_single_access i_axi_access (
    .axi_aclk    (axi_aclk),
    .axi_aresetn (axi_aresetn),
    .req_i       (req),
    .start_tgl_i (start_tgl),
    .cpl_valid_o (cpl_valid),
    .cpl_o       (cpl),
    .aw_valid_o  (m_axi_aw_valid_o),
    .aw_addr_o   (m_axi_aw_addr_o),
    .aw_size_o   (m_axi_aw_size_o),
    .aw_ready_i  (m_axi_aw_ready_i),
    .ar_valid_o  (m_axi_ar_valid_o),
    .ar_addr_o   (m_axi_ar_addr_o),
    .ar_size_o   (m_axi_ar_size_o),
    .ar_ready_i  (m_axi_ar_ready_i),
    .w_valid_o   (m_axi_w_valid_o),
    .w_data_o    (m_axi_w_data_o),
    .w_strb_o    (m_axi_w_strb_o),
    .w_last_o    (m_axi_w_last_o),
    .w_ready_i   (m_axi_w_ready_i),
    .b_valid_i   (m_axi_b_valid_i),
    .b_resp_i    (m_axi_b_resp_i),
    .b_ready_o   (m_axi_b_ready_o),
    .r_valid_i   (m_axi_r_valid_i),
    .r_data_i    (m_axi_r_data_i),
    .r_resp_i    (m_axi_r_resp_i),
    .r_ready_o   (m_axi_r_ready_o)
  );

  // Lane strobes of the held request set the read shift
  dbg_resp_align i_resp_align (
    .axi_aclk    (axi_aclk),
    .axi_aresetn (axi_aresetn),
    .cpl_valid_i (cpl_valid),
    .cpl_i       (cpl),
    .strb_i      (req.strb),
    .data_o      (data_o),
    .err_o       (err_o),
    .done_tgl_o  (done_tgl)
  );

endmodule

// ==== tests/tb_clock_gen.sv ====
/*
  Testbench clocks and resets
  axi_aclk at 100 ns, tck at 130 ns, both resets low for 5 axi_aclk cycles
*/
`timescale 1ns/100ps

module tb_clock_gen (
  output logic axi_aclk,
  output logic axi_aresetn,
  output logic tck_o,
  output logic trstn_o
);

  // Bus clock
  initial
  begin
    axi_aclk = 1'b0;
    forever #50 axi_aclk = ~axi_aclk;
  end

  // TCK offset so its falling edges never meet an axi_aclk edge
  initial
  begin
    tck_o = 1'b0;
    #30;
    forever
    begin
      tck_o = ~tck_o;
      #65;
    end
  end

  // Both resets leave together on a falling bus edge
  initial
  begin
    axi_aresetn = 1'b0;
    trstn_o     = 1'b0;
    repeat (5) @(posedge axi_aclk);
    @(negedge axi_aclk);
    axi_aresetn = 1'b1;
    trstn_o     = 1'b1;
  end

endmodule

// ==== tests/tb_dbg_axi_biu.sv ====
/*
  Testbench for the debug to AXI bus interface unit
  Randomly paced AXI slave, lane and alignment checks by assertion
*/
`timescale 1ns/100ps
`include "dbg_biu_defines.svh"

module tb_dbg_axi_biu
  import dbg_pkg::*;
  import axi_pkg::*;
();

  // 40 requests at 60 bus cycles each
  localparam int RUN_LIMIT = 40 * 60;

  logic                   tck, trstn, axi_aclk, axi_aresetn;
  logic                   strobe, rd_wrn, rdy, err;
  logic [`DBG_ADDR_W-1:0] addr;
  logic [`DBG_DATA_W-1:0] wdata_in, data_out;
  dbg_wsize_t             word_size;
  logic                   aw_valid, aw_ready, ar_valid, ar_ready;
  logic [`DBG_ADDR_W-1:0] aw_addr, ar_addr;
  axi_size_t              aw_size, ar_size;
  logic                   w_valid, w_ready, w_last;
  logic [`DBG_DATA_W-1:0] w_data, r_data;
  logic [`DBG_STRB_W-1:0] w_strb;
  logic                   b_valid, b_ready, r_valid, r_ready;
  axi_resp_t              b_resp, r_resp, resp_code;

  // Slave state
  logic [`DBG_DATA_W-1:0] mem [16];
  logic [4:0]             hs_req;
  logic [4:0]             hs_ack = '0;
  logic [4:0]             armed = '0;
  logic [1:0]             wait_cnt [5];
  logic [15:0]            lfsr_q = 16'd52920;
  int                     addr_hs_cnt;
  int                     access_cnt;
  int                     cycle_cnt = 0;

  // Expected request as seen on the bus
  logic [`DBG_ADDR_W-1:0] exp_addr;
  axi_size_t              exp_size;
  logic [`DBG_STRB_W-1:0] exp_strb;
  logic [`DBG_DATA_W-1:0] exp_wdata;

  tb_clock_gen i_clock_gen (
    .axi_aclk    (axi_aclk),
    .axi_aresetn (axi_aresetn),
    .tck_o       (tck),
    .trstn_o     (trstn)
  );

  dbg_axi_biu i_dut (
    .tck_i            (tck),
    .trstn_i          (trstn),
    .strobe_i         (strobe),
    .rd_wrn_i         (rd_wrn),
    .addr_i           (addr),
    .data_i           (wdata_in),
    .word_size_i      (word_size),
    .data_o           (data_out),
    .rdy_o            (rdy),
    .err_o            (err),
    .axi_aclk         (axi_aclk),
    .axi_aresetn      (axi_aresetn),
    .m_axi_aw_valid_o (aw_valid),
    .m_axi_aw_addr_o  (aw_addr),
    .m_axi_aw_size_o  (aw_size),
    .m_axi_aw_ready_i (aw_ready),
    .m_axi_ar_valid_o (ar_valid),
    .m_axi_ar_addr_o  (ar_addr),
    .m_axi_ar_size_o  (ar_size),
    .m_axi_ar_ready_i (ar_ready),
    .m_axi_w_valid_o  (w_valid),
    .m_axi_w_data_o   (w_data),
    .m_axi_w_strb_o   (w_strb),
    .m_axi_w_last_o   (w_last),
    .m_axi_w_ready_i  (w_ready),
    .m_axi_b_valid_i  (b_valid),
    .m_axi_b_resp_i   (b_resp),
    .m_axi_b_ready_o  (b_ready),
    .m_axi_r_valid_i  (r_valid),
    .m_axi_r_data_i   (r_data),
    .m_axi_r_resp_i   (r_resp),
    .m_axi_r_ready_o  (r_ready)
  );

  task automatic stop_on_error(input string what);
    $display("[FAIL] %0t ns: %s", $time, what);
    $display("Finished with errors");
    $fatal(1, "Stopped at first error");
  endtask

  // Taps at x^16 + x^14 + x^13 + x^11 + 1 with one step per bit
  function automatic logic [63:0] lfsr_take(input int nbits);
    logic [63:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < nbits; i++)
    begin
      fb    = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      val   = {val[62:0], fb};
    end
    return val;
  endfunction

  ////////////////////////////////////////
  // AXI slave model
  ////////////////////////////////////////

  // Channel order aw, ar, w, b, r
  assign aw_ready = hs_ack[0];
  assign ar_ready = hs_ack[1];
  assign w_ready  = hs_ack[2];
  assign b_valid  = hs_ack[3];
  assign r_valid  = hs_ack[4];
  assign b_resp   = resp_code;
  assign r_resp   = resp_code;
  assign r_data   = mem[ar_addr[6:3]];

  // Each ready or valid comes 0 to 3 cycles late and lasts one cycle
  always @(negedge axi_aclk)
  begin
    hs_req = {r_ready, b_ready, w_valid, ar_valid, aw_valid};
    for (int c = 0; c < 5; c++)
    begin
      if (!axi_aresetn || hs_ack[c])
      begin
        hs_ack[c] = 1'b0;
        armed[c]  = 1'b0;
      end
      else if (hs_req[c])
      begin
        if (!armed[c])
        begin
          wait_cnt[c] = 2'(lfsr_take(2));
          armed[c]    = 1'b1;
        end
        if (wait_cnt[c] == 2'd0)
          hs_ack[c] = 1'b1;
        else
          wait_cnt[c] = wait_cnt[c] - 2'd1;
      end
    end
  end

  // Memory filled during reset with every byte from its own address
  always @(posedge axi_aclk)
  begin
    if (!axi_aresetn)
    begin
      for (int i = 0; i < 16; i++)
        for (int k = 0; k < 8; k++)
          mem[i][8*k +: 8] <= 8'((i * 8 + k) * 37 + 11);
      addr_hs_cnt <= 0;
    end
    else
    begin
      if (w_valid && w_ready)
        for (int k = 0; k < 8; k++)
          if (w_strb[k])
            mem[aw_addr[6:3]][8*k +: 8] <= w_data[8*k +: 8];
      if ((aw_valid && aw_ready) || (ar_valid && ar_ready))
        addr_hs_cnt <= addr_hs_cnt + 1;
    end
  end

  always @(posedge axi_aclk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == RUN_LIMIT)
    begin
      $display("Timeout: run still busy after %0d axi_aclk cycles", RUN_LIMIT);
      $display("Finished with errors");
      $fatal(1, "Timeout");
    end
  end

  ////////////////////////////////////////
  // Bus checks
  ////////////////////////////////////////

  a_aw_payload : assert property (
    @(posedge axi_aclk) disable iff (!axi_aresetn)
    aw_valid && aw_ready |-> aw_addr == exp_addr && aw_size == exp_size
  ) else stop_on_error("AW address or size differs from the request");

  a_ar_payload : assert property (
    @(posedge axi_aclk) disable iff (!axi_aresetn)
    ar_valid && ar_ready |-> ar_addr == exp_addr && ar_size == exp_size
  ) else stop_on_error("AR address or size differs from the request");

  // Lanes and their data
  a_w_payload : assert property (
    @(posedge axi_aclk) disable iff (!axi_aresetn)
    w_valid && w_ready |-> w_strb == exp_strb && w_data == exp_wdata && w_last
  ) else stop_on_error("W strobes or lane data wrong");

  // Each valid stays up until its own ready
  a_aw_valid_hold : assert property (
    @(posedge axi_aclk) disable iff (!axi_aresetn)
    aw_valid && !aw_ready |=> aw_valid
  ) else stop_on_error("AW valid dropped before ready");

  a_ar_valid_hold : assert property (
    @(posedge axi_aclk) disable iff (!axi_aresetn)
    ar_valid && !ar_ready |=> ar_valid
  ) else stop_on_error("AR valid dropped before ready");

  a_w_valid_hold : assert property (
    @(posedge axi_aclk) disable iff (!axi_aresetn)
    w_valid && !w_ready |=> w_valid
  ) else stop_on_error("W valid dropped before ready");

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  function automatic int byte_count(input logic [3:0] ws);
    case (ws)
      4'h1: return 1;
      4'h2: return 2;
      4'h4: return 4;
      default: return 8;
    endcase
  endfunction

  // 8 byte, 4 half-word, 2 word, 1 double and 1 unknown-code access
  function automatic logic [3:0] combo_size(input int j);
    if (j < 8)
      return 4'h1;
    else if (j < 12)
      return 4'h2;
    else if (j < 14)
      return 4'h4;
    else if (j == 14)
      return 4'h8;
    else
      return 4'h3;
  endfunction

  function automatic logic [31:0] combo_addr(input int j);
    logic [2:0] low;
    if (j < 8)
      low = 3'(j);
    else if (j < 12)
      low = 3'(2 * (j - 8));
    else if (j < 14)
      low = 3'(4 * (j - 12));
    else if (j == 14)
      low = 3'd0;
    else
      low = 3'd5;
    return 32'h0000_1000 + 32'(j * 8) + 32'(low);
  endfunction

  // One debug access from strobe to rdy and then result checks
  task automatic run_access(input logic is_read, input logic [31:0] a,
                            input logic [3:0] ws, input logic [63:0] d);
    int          n;
    logic [2:0]  lo;
    logic [63:0] mask;
    logic [63:0] exp_rd;
    n         = byte_count(ws);
    lo        = a[2:0] & ~3'(n - 1);
    mask      = (n == 8) ? {64{1'b1}} : ((64'd1 << (8 * n)) - 64'd1);
    exp_addr  = a;
    exp_size  = axi_size_t'(3'($clog2(n)));
    exp_strb  = '0;
    exp_wdata = '0;
    // Top n bytes of the shifted word land from the lowest lane up
    for (int k = 0; k < n; k++)
    begin
      exp_strb[3'(lo + k)]           = 1'b1;
      exp_wdata[8 * (lo + k) +: 8] = d[8 * (8 - n + k) +: 8];
    end
    exp_rd = (mem[a[6:3]] >> (8 * lo)) & mask;

    strobe    = 1'b1;
    rd_wrn    = is_read;
    addr      = a;
    wdata_in  = d;
    word_size = dbg_wsize_t'(ws);
    @(negedge tck);
    strobe = 1'b0;
    // Busy now so this strobe must not start another access
    if (!rdy)
    begin
      strobe = 1'b1;
      addr   = a ^ 32'h0000_0040;
      @(negedge tck);
      strobe = 1'b0;
    end
    while (!rdy)
      @(negedge tck);
    access_cnt++;

    assert (addr_hs_cnt == access_cnt)
      else stop_on_error($sformatf("%0d address handshakes for %0d accesses",
                                   addr_hs_cnt, access_cnt));
    assert (err == (resp_code != `DBG_RESP_OKAY))
      else stop_on_error($sformatf("err_o %0b with response %0d", err, resp_code));
    if (is_read)
      assert ((data_out & mask) == exp_rd)
        else stop_on_error($sformatf("read at %h gave %h, expected %h",
                                     a, data_out & mask, exp_rd));
  endtask

  initial
  begin
    strobe     = 1'b0;
    rd_wrn     = 1'b1;
    addr       = '0;
    wdata_in   = '0;
    word_size  = DBG_WSIZE_8;
    resp_code  = `DBG_RESP_OKAY;
    access_cnt = 0;
    wait (trstn && axi_aresetn);
    @(negedge tck);

    // Idle state straight out of reset
    assert (rdy && !err && data_out == '0)
      else stop_on_error("debug port not idle after reset");
    assert (!aw_valid && !ar_valid && !w_valid && !w_last && !b_ready && !r_ready)
      else stop_on_error("AXI valid or ready high after reset");

    // Every lane pattern written and then read back
    for (int j = 0; j < 16; j++)
      run_access(1'b0, combo_addr(j), combo_size(j), lfsr_take(64));
    for (int j = 0; j < 16; j++)
      run_access(1'b1, combo_addr(j), combo_size(j), '0);

    // SLVERR on a read and a write and then cleared by an OKAY read
    resp_code = 2'b10;
    run_access(1'b1, combo_addr(9), combo_size(9), '0);
    run_access(1'b0, combo_addr(12), combo_size(12), lfsr_take(64));
    resp_code = `DBG_RESP_OKAY;
    run_access(1'b1, combo_addr(12), combo_size(12), '0);

    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+src
src/axi_pkg.sv
src/dbg_pkg.sv
src/dbg_req_capture.sv
src/axi_single_access.sv
src/dbg_resp_align.sv
src/dbg_axi_biu.sv
tests/tb_clock_gen.sv
tests/tb_dbg_axi_biu.sv

// ==== Makefile ====
# Verilator build and run for the debug to AXI bus interface unit

TOP := tb_dbg_axi_biu

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): vlog.f $(wildcard src/*.sv src/*.svh tests/*.sv)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module $(TOP) -f vlog.f -Mdir obj_dir

# Pass only when the log holds the pass line
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
